// File: vlog.f
hw/pcs_pkg.sv
hw/block_type_decoder.sv
hw/block_encoder.sv
hw/bram.sv
hw/bram_control.sv
hw/pcs_capture_top.sv
bench/tb_pcs_capture.sv

// File: Bender.yml
package:
  name: pcs_capture

sources:
  # package first, then the pipeline stages and the top level
  - hw/pcs_pkg.sv
  - hw/block_type_decoder.sv
  - hw/block_encoder.sv
  - hw/bram.sv
  - hw/bram_control.sv
  - hw/pcs_capture_top.sv

  # testbench, top module tb_pcs_capture
  - target: simulation
    files:
      - bench/tb_pcs_capture.sv

// File: bench/tb_pcs_capture.sv
//**************************************************************************
// pcs capture testbench
// drives xgmii words through the capture top level, runs several
// captures and checks the readback against a reference encoder
//**************************************************************************
`timescale 1ns/1ps

module tb_pcs_capture
    import pcs_pkg::*;
();

    localparam int RAM_ADDR_NBIT = 5;
    localparam int RAM_DEPTH     = 2 ** RAM_ADDR_NBIT;
    localparam int CAPTURES      = 4;
    // reset plus a generous bound per capture
    localparam int WATCHDOG_CYCLES = 16 + 4 * (CAPTURES * (8 + 4 * RAM_DEPTH));

    // expected coded block with its type
    typedef struct packed {
        coded_block_t block;
        block_type_e  btype;
    } expect_t;

    logic                     i_clock;
    logic                     i_reset;
    xgmii_word_t              i_word;
    logic                     i_run;
    logic [RAM_ADDR_NBIT-1:0] i_read_addr;
    coded_block_t             o_read_block;
    block_type_e              o_read_type;
    logic                     o_mem_full;

    integer  seed = 32'h15fea117;
    expect_t expected [$];

    pcs_capture_top #(
        .RAM_ADDR_NBIT (RAM_ADDR_NBIT)
    ) DUT (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_word       (i_word),
        .i_run        (i_run),
        .i_read_addr  (i_read_addr),
        .o_read_block (o_read_block),
        .o_read_type  (o_read_type),
        .o_mem_full   (o_mem_full)
    );

    // 4 ns period
    always #2 i_clock = ~i_clock;

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_block(input int addr, input coded_block_t got, input coded_block_t exp);
        if (got !== exp)
        begin
            $display("Mismatch o_read_block addr %0d: got %h expected %h", addr, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_type(input int addr, input block_type_e got, input block_type_e exp);
        if (got !== exp)
        begin
            $display("Mismatch o_read_type addr %0d: got %h expected %h", addr, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Mismatch o_mem_full: got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [7:0] term_field(input int k);
        logic [7:0] fields [8];
        fields = '{FIELD_TERM0, FIELD_TERM1, FIELD_TERM2, FIELD_TERM3,
                   FIELD_TERM4, FIELD_TERM5, FIELD_TERM6, FIELD_TERM7};
        return fields[k];
    endfunction

    // classify the word, then build the 66-bit block from the block rules
    function automatic expect_t encode_ref(input xgmii_data_t data, input xgmii_ctrl_t ctrl);
        expect_t     r;
        logic [63:0] payload;
        logic        match;
        int          kt;
        r.btype = BT_ERROR;
        payload = '0;
        if (ctrl == '0)
            r.btype = BT_DATA;
        else if ((ctrl == 8'hFF) && (data == {8{CH_IDLE}}))
            r.btype = BT_IDLE;
        else if ((ctrl == 8'h01) && (data[7:0] == CH_START))
            r.btype = BT_START;
        else
        begin
            for (int k = 0; k < 8; k++)
            begin
                // data below k, terminate at k, idle above
                match = ctrl[k] && (data[8*k +: 8] == CH_TERM);
                for (int j = 0; j < 8; j++)
                begin
                    if ((j < k) && ctrl[j])
                        match = 1'b0;
                    if ((j > k) && !(ctrl[j] && (data[8*j +: 8] == CH_IDLE)))
                        match = 1'b0;
                end
                if (match)
                    r.btype = block_type_e'(BT_TERM0 + k);
            end
        end
        case (r.btype)
            BT_DATA:  payload = data;
            BT_IDLE:  payload = {56'h0, FIELD_IDLE};
            BT_START: payload = {data[63:8], FIELD_START};
            BT_ERROR:
            begin
                payload[7:0] = FIELD_ERROR;
                for (int j = 0; j < 8; j++)
                    payload[8 + 7*j +: 7] = 7'h1E;
            end
            default:
            begin
                kt = int'(r.btype) - int'(BT_TERM0);
                payload[7:0] = term_field(kt);
                // data lanes 0..k-1 follow the field byte
                for (int j = 0; j < kt; j++)
                    payload[8*(j+1) +: 8] = data[8*j +: 8];
            end
        endcase
        r.block = {payload, (r.btype == BT_DATA) ? SYNC_DATA : SYNC_CTRL};
        return r;
    endfunction

    task automatic set_control(inout xgmii_data_t data, inout xgmii_ctrl_t ctrl,
                               input int lane, input logic [7:0] ch);
        data[8*lane +: 8] = ch;
        ctrl[lane]        = 1'b1;
    endtask

    // kind 0 random data, 1 legal control blocks, 2 malformed words
    task automatic make_word(input int kind, input int idx,
                             output xgmii_data_t data, output xgmii_ctrl_t ctrl);
        int k;
        data = {$random(seed), $random(seed)};
        ctrl = '0;
        if (kind == 1)
        begin
            k = idx % 10;
            if (k == 0)
            begin
                data = {8{CH_IDLE}};
                ctrl = 8'hFF;
            end
            else if (k == 1)
                set_control(data, ctrl, 0, CH_START);
            else
            begin
                // terminate in lane k-2, idle above it
                set_control(data, ctrl, k - 2, CH_TERM);
                for (int j = k - 1; j < 8; j++)
                    set_control(data, ctrl, j, CH_IDLE);
            end
        end
        else if (kind == 2)
        begin
            k = idx % 3;
            if (k == 0)
            begin
                // terminate followed by a non-idle control lane
                k = {$random(seed)} % 7;
                set_control(data, ctrl, k, CH_TERM);
                set_control(data, ctrl, k + 1, CH_ERROR);
                for (int j = k + 2; j < 8; j++)
                    set_control(data, ctrl, j, CH_IDLE);
            end
            else if (k == 1)
                set_control(data, ctrl, 1 + ({$random(seed)} % 7), CH_START);
            else
                // never pure data, never exactly a lane 0 start
                ctrl = xgmii_ctrl_t'($random(seed)) | 8'h02;
        end
    endtask

    task automatic drive_word(input xgmii_data_t data, input xgmii_ctrl_t ctrl);
        @(negedge i_clock);
        i_word.data  = data;
        i_word.ctrl  = ctrl;
        i_word.valid = 1'b1;
        // only the first RAM_DEPTH blocks land in memory
        if (expected.size() < RAM_DEPTH)
            expected.push_back(encode_ref(data, ctrl));
    endtask

    task automatic run_capture(input int kind);
        xgmii_data_t data;
        xgmii_ctrl_t ctrl;
        expect_t     exp;
        expected.delete();
        // run pulse with valid low
        @(negedge i_clock);
        i_word.valid = 1'b0;
        i_run        = 1'b1;
        @(negedge i_clock);
        i_run = 1'b0;
        repeat (4) @(negedge i_clock);
        check_flag(o_mem_full, 1'b0);
        // twice the depth so the second half must be dropped
        for (int i = 0; i < 2 * RAM_DEPTH; i++)
        begin
            make_word(kind, i, data, ctrl);
            drive_word(data, ctrl);
        end
        @(negedge i_clock);
        i_word.valid = 1'b0;
        wait (o_mem_full === 1'b1);
        // readback with one cycle read latency
        for (int a = 0; a < RAM_DEPTH; a++)
        begin
            @(negedge i_clock);
            i_read_addr = RAM_ADDR_NBIT'(a);
            @(negedge i_clock);
            exp = expected[a];
            check_block(a, o_read_block, exp.block);
            check_type(a, o_read_type, exp.btype);
        end
    endtask

    initial
    begin
        i_clock     = 1'b0;
        i_reset     = 1'b1;
        i_word      = '0;
        i_run       = 1'b0;
        i_read_addr = '0;
        repeat (16) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        // idle after reset means full
        check_flag(o_mem_full, 1'b1);
        run_capture(0);
        run_capture(1);
        run_capture(2);
        // new data replaces the previous capture
        run_capture(0);
        $display("NO ERRORS");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        $display("timeout, the capture never completed");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: hw/pcs_capture_top.sv
//**************************************************************************
// pcs capture top level
// xgmii word -> block type decoder -> 64b/66b encoder -> capture rams,
// with a readback port on the captured blocks and types
//**************************************************************************
`timescale 1ns/1ps

module pcs_capture_top
    import pcs_pkg::*;
#(
    parameter int RAM_ADDR_NBIT = 5
)
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  xgmii_word_t              i_word,
    input  logic                     i_run,
    input  logic [RAM_ADDR_NBIT-1:0] i_read_addr,
    output coded_block_t             o_read_block,
    output block_type_e              o_read_type,
    output logic                     o_mem_full
);

    // decode stage to execute stage
    decoded_word_t decoded;
    // execute stage to result stage
    coded_block_t  coded_block;
    block_type_e   coded_type;
    logic          coded_valid;

    // one cycle, classify the word
    block_type_decoder u_decoder (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_word    (i_word),
        .o_decoded (decoded)
    );

    // one cycle, build the coded block
    block_encoder u_encoder (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_decoded (decoded),
        .o_block   (coded_block),
        .o_type    (coded_type),
        .o_valid   (coded_valid)
    );

    // capture and readback
    bram_control #(
        .RAM_ADDR_NBIT (RAM_ADDR_NBIT)
    ) u_bram_control (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_valid      (coded_valid),
        .i_data_coded (coded_block),
        .i_data_type  (coded_type),
        .i_read_addr  (i_read_addr),
        .o_data_coded (o_read_block),
        .o_data_type  (o_read_type),
        .o_mem_full   (o_mem_full)
    );

endmodule

// File: hw/bram_control.sv
//**************************************************************************
// capture controller
// a rising edge on i_run arms a capture of RAM_DEPTH coded blocks and
// their type codes into two rams sharing one address counter, with a
// readback port for the stored pairs
//**************************************************************************
`timescale 1ns/1ps

module bram_control
    import pcs_pkg::*;
#(
    parameter int RAM_ADDR_NBIT = 5
)
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_run,
    input  logic                     i_valid,
    input  coded_block_t             i_data_coded,
    input  block_type_e              i_data_type,
    input  logic [RAM_ADDR_NBIT-1:0] i_read_addr,
    output coded_block_t             o_data_coded,
    output block_type_e              o_data_type,
    output logic                     o_mem_full
);

    localparam int RAM_DEPTH = 2 ** RAM_ADDR_NBIT;
    localparam logic [RAM_ADDR_NBIT-1:0] LAST_ADDR = RAM_ADDR_NBIT'(RAM_DEPTH - 1);

    logic                     run_q;
    logic                     run_edge;
    logic [RAM_ADDR_NBIT-1:0] addr_counter;
    // same enable and address for both memories
    logic                     write_enable;
    logic [TYPE_W-1:0]        type_read;

    assign run_edge = i_run && !run_q;

    // blocks arriving while full are dropped, nothing is written on the edge cycle
    assign write_enable = i_valid && !o_mem_full && !run_edge;

    // full high after reset means idle with no capture pending
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            run_q        <= 1'b0;
            addr_counter <= '0;
            o_mem_full   <= 1'b1;
        end
        else
        begin
            run_q <= i_run;
            if (run_edge)
            begin
                // restart, also mid capture
                addr_counter <= '0;
                o_mem_full   <= 1'b0;
            end
            else if (write_enable)
            begin
                addr_counter <= addr_counter + 1'b1;
                // last location written, stop capturing
                if (addr_counter == LAST_ADDR)
                    o_mem_full <= 1'b1;
            end
        end
    end

    // coded block store
    bram #(
        .RAM_WIDTH     (BLOCK_W),
        .RAM_ADDR_NBIT (RAM_ADDR_NBIT)
    ) u_bram_block (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (addr_counter),
        .i_data         (i_data_coded),
        .i_read_addr    (i_read_addr),
        .o_data         (o_data_coded)
    );

    // block type store
    bram #(
        .RAM_WIDTH     (TYPE_W),
        .RAM_ADDR_NBIT (RAM_ADDR_NBIT)
    ) u_bram_type (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (addr_counter),
        .i_data         (i_data_type),
        .i_read_addr    (i_read_addr),
        .o_data         (type_read)
    );

    assign o_data_type = block_type_e'(type_read);

endmodule

// File: hw/bram.sv
//**************************************************************************
// simple dual-port block ram
// one write port and one read port with a registered output
//**************************************************************************
`timescale 1ns/1ps

module bram
#(
    parameter int RAM_WIDTH     = 66,
    parameter int RAM_ADDR_NBIT = 5
)
(
    input  logic                     i_clock,
    input  logic                     i_write_enable,
    input  logic [RAM_ADDR_NBIT-1:0] i_write_addr,
    input  logic [RAM_WIDTH-1:0]     i_data,
    input  logic [RAM_ADDR_NBIT-1:0] i_read_addr,
    output logic [RAM_WIDTH-1:0]     o_data
);

    localparam int RAM_DEPTH = 2 ** RAM_ADDR_NBIT;

    logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];

    // write on the clock edge when enabled
    always_ff @(posedge i_clock)
    begin
        if (i_write_enable)
            mem[i_write_addr] <= i_data;
    end

    // read data one cycle after the address
    always_ff @(posedge i_clock)
    begin
        o_data <= mem[i_read_addr];
    end

endmodule

// File: hw/block_encoder.sv
//**************************************************************************
// 64b/66b block encoder
// builds the 66-bit coded block from a classified xgmii word: sync
// header, block type field and lane payload, registered with its type
//**************************************************************************
`timescale 1ns/1ps

module block_encoder
    import pcs_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_reset,
    input  decoded_word_t i_decoded,
    output coded_block_t  o_block,
    output block_type_e   o_type,
    output logic          o_valid
);

    // terminate lane index, only meaningful for BT_TERM0..BT_TERM7
    logic [2:0]   term_k;
    // keeps data lanes 0..k-1 of a terminate block
    xgmii_data_t  keep_mask;
    xgmii_data_t  term_data;
    logic [7:0]   field;
    // the seven bytes after the field byte
    logic [55:0]  body;
    xgmii_data_t  payload;
    logic [1:0]   sync;
    coded_block_t block_next;

    assign term_k    = 3'(i_decoded.block_type - BT_TERM0);
    assign keep_mask = (64'h1 << (8 * term_k)) - 64'h1;
    assign term_data = i_decoded.data & keep_mask;

    // field byte per block type
    always_comb
    begin
        case (i_decoded.block_type)
            BT_START: field = FIELD_START;
            BT_TERM0: field = FIELD_TERM0;
            BT_TERM1: field = FIELD_TERM1;
            BT_TERM2: field = FIELD_TERM2;
            BT_TERM3: field = FIELD_TERM3;
            BT_TERM4: field = FIELD_TERM4;
            BT_TERM5: field = FIELD_TERM5;
            BT_TERM6: field = FIELD_TERM6;
            BT_TERM7: field = FIELD_TERM7;
            BT_ERROR: field = FIELD_ERROR;
            default:  field = FIELD_IDLE;
        endcase
    end

    // lane content after the field byte
    always_comb
    begin
        case (i_decoded.block_type)
            // lanes 1..7 follow the start field
            BT_START:
                body = i_decoded.data[63:8];
            BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
            BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7:
                body = term_data[55:0];
            // eight 7-bit error codes fill the block
            BT_ERROR:
                body = {8{CODE_ERROR}};
            // idle, eight idle codes
            default:
                body = {8{CODE_IDLE}};
        endcase
    end

    // data blocks carry the word verbatim
    assign payload    = i_decoded.is_control ? {body, field} : i_decoded.data;
    assign sync       = i_decoded.is_control ? SYNC_CTRL : SYNC_DATA;
    assign block_next = {payload, sync};

    // block and type unreset
    always_ff @(posedge i_clock)
    begin
        o_block <= block_next;
        o_type  <= i_decoded.block_type;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_decoded.valid;
    end

endmodule

// File: hw/block_type_decoder.sv
//**************************************************************************
// block type decoder
// classifies one xgmii word into a 64b/66b block type, checking all
// lanes in parallel, and registers the result toward the encoder
//**************************************************************************
`timescale 1ns/1ps

module block_type_decoder
    import pcs_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_reset,
    input  xgmii_word_t   i_word,
    output decoded_word_t o_decoded
);

    // lane n is data byte n with control flag n
    logic [7:0]    lane_char [XGMII_CTRL_W];
    xgmii_ctrl_t   data_mask;
    xgmii_ctrl_t   idle_mask;
    xgmii_ctrl_t   term_mask;
    // term_hit[k] set when the word is a legal terminate in lane k
    xgmii_ctrl_t   term_hit;
    block_type_e   type_next;
    decoded_word_t decoded_next;

    // per-lane character checks
    for (genvar n = 0; n < XGMII_CTRL_W; n++)
    begin : g_lane
        assign lane_char[n] = i_word.data[8*n +: 8];
        assign data_mask[n] = ~i_word.ctrl[n];
        assign idle_mask[n] = i_word.ctrl[n] && (lane_char[n] == CH_IDLE);
        assign term_mask[n] = i_word.ctrl[n] && (lane_char[n] == CH_TERM);
    end

    // terminate in lane k: data below, terminate at k, idle above
    for (genvar k = 0; k < XGMII_CTRL_W; k++)
    begin : g_term
        localparam xgmii_ctrl_t LOW_LANES  = xgmii_ctrl_t'((1 << k) - 1);
        localparam xgmii_ctrl_t HIGH_LANES = ~xgmii_ctrl_t'((2 << k) - 1);

        assign term_hit[k] = ((data_mask & LOW_LANES) == LOW_LANES)
                           && term_mask[k]
                           && ((idle_mask & HIGH_LANES) == HIGH_LANES);
    end

    // anything not matching a kept block type falls to error
    always_comb
    begin
        type_next = BT_ERROR;
        if (i_word.ctrl == '0)
            type_next = BT_DATA;
        else if (&idle_mask)
            type_next = BT_IDLE;
        else if ((i_word.ctrl == 8'h01) && (lane_char[0] == CH_START))
            type_next = BT_START;
        else
        begin
            // at most one terminate position can match
            for (int k = 0; k < XGMII_CTRL_W; k++)
            begin
                if (term_hit[k])
                    type_next = block_type_e'(BT_TERM0 + k);
            end
        end
    end

    assign decoded_next = '{
        block_type: type_next,
        data:       i_word.data,
        is_control: |i_word.ctrl,
        valid:      i_word.valid
    };

    // type and data travel unreset, valid clears
    always_ff @(posedge i_clock)
    begin
        o_decoded <= decoded_next;
        if (i_reset)
            o_decoded.valid <= 1'b0;
    end

endmodule

// File: hw/pcs_pkg.sv
//**************************************************************************
// pcs capture package
// widths, xgmii control characters and 64b/66b block type fields,
// the block type enum and the structs passed between pipeline stages
//**************************************************************************
package pcs_pkg;

    // xgmii word widths
    localparam int XGMII_DATA_W = 64;
    localparam int XGMII_CTRL_W = 8;

    // coded block and stored type code widths
    localparam int BLOCK_W = 66;
    localparam int TYPE_W  = 4;

    typedef logic [XGMII_DATA_W-1:0] xgmii_data_t;
    typedef logic [XGMII_CTRL_W-1:0] xgmii_ctrl_t;

    // sync header in [1:0], payload in [65:2], lane 0 in the lowest bits
    typedef logic [BLOCK_W-1:0] coded_block_t;

    // xgmii control characters
    localparam logic [7:0] CH_IDLE  = 8'h07;
    localparam logic [7:0] CH_START = 8'hFB;
    localparam logic [7:0] CH_TERM  = 8'hFD;
    localparam logic [7:0] CH_ERROR = 8'hFE;

    // block type field bytes, first payload byte of a control block
    localparam logic [7:0] FIELD_IDLE  = 8'h1E;
    localparam logic [7:0] FIELD_START = 8'h78;
    localparam logic [7:0] FIELD_TERM0 = 8'h87;
    localparam logic [7:0] FIELD_TERM1 = 8'h99;
    localparam logic [7:0] FIELD_TERM2 = 8'hAA;
    localparam logic [7:0] FIELD_TERM3 = 8'hB4;
    localparam logic [7:0] FIELD_TERM4 = 8'hCC;
    localparam logic [7:0] FIELD_TERM5 = 8'hD2;
    localparam logic [7:0] FIELD_TERM6 = 8'hE1;
    localparam logic [7:0] FIELD_TERM7 = 8'hFF;
    // error shares the idle field, the lane codes tell them apart
    localparam logic [7:0] FIELD_ERROR = 8'h1E;

    // 7-bit lane codes inside a control block
    localparam logic [6:0] CODE_IDLE  = 7'h00;
    localparam logic [6:0] CODE_ERROR = 7'h1E;

    // sync headers
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // block types in code order, also the stored type code
    typedef enum logic [TYPE_W-1:0] {
        BT_DATA,
        BT_IDLE,
        BT_START,
        BT_TERM0,
        BT_TERM1,
        BT_TERM2,
        BT_TERM3,
        BT_TERM4,
        BT_TERM5,
        BT_TERM6,
        BT_TERM7,
        BT_ERROR
    } block_type_e;

    // one xgmii transfer, 73 bits
    typedef struct packed {
        xgmii_data_t data;
        xgmii_ctrl_t ctrl;
        logic        valid;
    } xgmii_word_t;

    // classified word toward the encoder, 70 bits
    typedef struct packed {
        block_type_e block_type;
        xgmii_data_t data;
        // any lane carried control, so the block takes the control sync header
        logic        is_control;
        logic        valid;
    } decoded_word_t;

endpackage
